// ==== hdl/oflow_pkg.sv ====
`default_nettype none

package oflow_pkg;

	// ----------------------------------------------------------
	// sizes
	// ----------------------------------------------------------
	localparam int PE_NUM    = 24;                 // lanes per set
	localparam int MEM_DEPTH = 256;                // boxes held for the previous frame
	localparam int LANE_W    = $clog2(PE_NUM);     // 5 bits to count 24 lanes

	typedef logic [7:0]        coord_t;            // box center or size
	typedef logic [7:0]        bbox_idx_t;         // memory index, also a box count
	typedef logic [3:0]        set_cnt_t;          // up to 11 sets, 256/24 rounded up
	typedef logic [9:0]        score_t;            // lower is a better match
	typedef logic [8:0]        metric_t;           // one partial metric, max 510
	typedef logic [LANE_W-1:0] lane_idx_t;         // lane number inside a set

	typedef logic [PE_NUM-1:0] lane_mask_t;        // one valid bit per lane
	typedef metric_t [PE_NUM-1:0] metric_vec_t;

	// ----------------------------------------------------------
	// structs
	// ----------------------------------------------------------
	typedef struct packed {
		coord_t x;                                 // center
		coord_t y;
		coord_t w;                                 // size
		coord_t h;
	} bbox_t;                                      // 32 bits

	typedef struct packed {
		bbox_t [PE_NUM-1:0] lanes;
		lane_mask_t         valid;
		bbox_idx_t          base;                  // memory index of lane 0
	} set_t;

	typedef struct packed {
		logic      found;
		bbox_idx_t idx;
		score_t    score;
	} match_t;

	// |a0-b0| + |a1-b1|, shared by both metric units
	function automatic metric_t l1_dist(coord_t a0, coord_t a1, coord_t b0, coord_t b1);
		coord_t d0;
		coord_t d1;
		d0 = (a0 > b0) ? a0 - b0 : b0 - a0;
		d1 = (a1 > b1) ? a1 - b1 : b1 - a1;
		return metric_t'(d0) + metric_t'(d1); // 255+255 still fits in 9 bits
	endfunction

endpackage

`default_nettype wire

// ==== hdl/oflow_bbox_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

// box store of the previous frame, one write port and one registered read port
module oflow_bbox_mem (
	input  logic                clk,
	input  logic                wr_en,
	input  oflow_pkg::bbox_idx_t wr_addr,
	input  oflow_pkg::bbox_t    wr_data,
	input  oflow_pkg::bbox_idx_t rd_addr,
	output oflow_pkg::bbox_t    rd_data
);

	oflow_pkg::bbox_t mem [oflow_pkg::MEM_DEPTH];

	// write side, one entry per cycle from outside
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// data shows up the cycle after its address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hdl/oflow_core_fsm_read.sv ====
`timescale 1ns/1ns
`default_nettype none

module oflow_core_fsm_read (
	input  logic                 clk,
	input  logic                 reset_N,
	input  oflow_pkg::bbox_idx_t num_of_bbox_in_frame, // level, stable during a search
	input  logic                 start_read_mem_for_first_set, // start pulse of the frame
	input  logic                 done_read,         // from buffer reader
	input  logic                 done_registration, // from registration, set finished
	output logic                 start_read,        // to buffer reader
	output logic                 frame_done,        // last set scored
	output oflow_pkg::set_cnt_t  set_index          // set being read
);

	// ----------------------------------------------------------
	// declarations
	// ----------------------------------------------------------
	typedef enum logic [1:0] {
		idle_st,
		reading_st,
		wait_reg_st
	} state_t;

	state_t              state;
	state_t              next_state;
	oflow_pkg::set_cnt_t set_cnt;   // finished sets
	oflow_pkg::set_cnt_t stop_cnt;  // sets in this frame
	logic                last_set;
	logic                empty_frame;

	// sets = ceil(count / 24), 0 for an empty frame
	assign stop_cnt = oflow_pkg::set_cnt_t'((num_of_bbox_in_frame + oflow_pkg::PE_NUM - 1) /
		oflow_pkg::PE_NUM);
	assign last_set    = (set_cnt + 1'b1) == stop_cnt;   // the set now in registration
	assign empty_frame = stop_cnt == '0;
	assign set_index   = set_cnt;                        // finished sets == next set to read

	// ----------------------------------------------------------
	// state register
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= idle_st;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle_st: begin
				// empty frame never leaves idle
				if (start_read_mem_for_first_set && !empty_frame) next_state = reading_st;
			end
			reading_st: begin
				if (done_read) next_state = wait_reg_st;
			end
			wait_reg_st: begin
				if (done_registration) next_state = last_set ? idle_st : reading_st;
			end
			default: next_state = idle_st;
		endcase
	end

	// ----------------------------------------------------------
	// set counter and output pulses
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			set_cnt    <= '0;
			start_read <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			if (state == idle_st) set_cnt <= '0;
			else if (state == wait_reg_st && done_registration) set_cnt <= set_cnt + 1'b1;

			start_read <= next_state == reading_st && state != reading_st; // every entry
			frame_done <= (state == idle_st && start_read_mem_for_first_set && empty_frame) ||
				(state == wait_reg_st && done_registration && last_set);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/oflow_buffer_read.sv ====
`timescale 1ns/1ns
`default_nettype none

module oflow_buffer_read (
	input  logic                 clk,
	input  logic                 reset_N,
	input  logic                 start_read,           // one pulse per set
	input  oflow_pkg::set_cnt_t  set_index,
	input  oflow_pkg::bbox_idx_t num_of_bbox_in_frame,
	output oflow_pkg::bbox_idx_t rd_addr,              // to memory
	input  oflow_pkg::bbox_t     rd_data,              // one cycle after rd_addr
	output oflow_pkg::set_t      set,
	output logic                 done_read
);

	localparam oflow_pkg::lane_idx_t LAST_LANE = oflow_pkg::lane_idx_t'(oflow_pkg::PE_NUM - 1);

	oflow_pkg::bbox_idx_t base;        // index of lane 0
	oflow_pkg::lane_idx_t lane_cnt;    // next lane to issue after the first
	logic                 busy;
	logic                 issue_en;
	oflow_pkg::lane_idx_t issue_lane;
	logic                 cap_en;      // rd_data holds a lane this cycle
	oflow_pkg::lane_idx_t cap_lane;
	logic [8:0]           cap_pos;     // 9 bits, tail of set 10 runs past 255

	assign base = oflow_pkg::bbox_idx_t'(set_index * oflow_pkg::PE_NUM);

	// ----------------------------------------------------------
	// address side
	// ----------------------------------------------------------
	// lane 0 goes out with start_read itself so the memory latency overlaps
	assign issue_en   = start_read || busy;
	assign issue_lane = start_read ? '0 : lane_cnt;
	assign rd_addr    = base + oflow_pkg::bbox_idx_t'(issue_lane); // wraps only on invalid lanes

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy     <= 1'b0;
			lane_cnt <= '0;
		end else if (start_read) begin
			busy     <= 1'b1;
			lane_cnt <= oflow_pkg::lane_idx_t'(1);
		end else if (busy) begin
			if (lane_cnt == LAST_LANE) busy <= 1'b0; // 24th address issued
			lane_cnt <= lane_cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------
	// capture side, trails the address by one cycle
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			cap_en    <= 1'b0;
			cap_lane  <= '0;
			done_read <= 1'b0;
		end else begin
			cap_en    <= issue_en;
			cap_lane  <= issue_lane;
			done_read <= cap_en && cap_lane == LAST_LANE; // set complete next cycle
		end
	end

	assign cap_pos = {1'b0, base} + 9'(cap_lane);

	always_ff @(posedge clk) begin
		if (start_read) set.base <= base;
		if (cap_en) begin
			set.lanes[cap_lane] <= rd_data;
			set.valid[cap_lane] <= cap_pos < {1'b0, num_of_bbox_in_frame}; // past frame end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/oflow_center_metric.sv ====
`timescale 1ns/1ns
`default_nettype none

// center distance, |dx| + |dy| per lane
module oflow_center_metric (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   done_read,
	input  oflow_pkg::set_t        set,
	input  oflow_pkg::bbox_t       query_bbox,
	output oflow_pkg::metric_vec_t center_dist,
	output logic                   done_similarity_metric
);

	// ----------------------------------------------------------
	// 24 lanes in parallel, loaded once per set
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (done_read) begin
			for (int i = 0; i < oflow_pkg::PE_NUM; i++) begin
				center_dist[i] <= oflow_pkg::l1_dist(set.lanes[i].x, set.lanes[i].y,
					query_bbox.x, query_bbox.y);
			end
		end
	end

	// size unit runs in lockstep, so this one pulse covers both
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			done_similarity_metric <= 1'b0;
		end else begin
			done_similarity_metric <= done_read;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/oflow_size_metric.sv ====
`timescale 1ns/1ns
`default_nettype none

// size difference, |dw| + |dh| per lane
module oflow_size_metric (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   done_read,
	input  oflow_pkg::set_t        set,
	input  oflow_pkg::bbox_t       query_bbox,
	output oflow_pkg::metric_vec_t size_diff
);

	oflow_pkg::metric_vec_t size_diff_d;  // next value per lane

	always_comb begin
		for (int i = 0; i < oflow_pkg::PE_NUM; i++) begin
			size_diff_d[i] = oflow_pkg::l1_dist(set.lanes[i].w, set.lanes[i].h,
				query_bbox.w, query_bbox.h);
		end
	end

	// loaded once per set, same timing as center unit
	// held until the next done_read, registration samples after done_similarity_metric
	always_ff @(posedge clk) begin
		if (done_read) size_diff <= size_diff_d;
	end

endmodule

`default_nettype wire

// ==== hdl/oflow_registration.sv ====
`timescale 1ns/1ns
`default_nettype none

module oflow_registration (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   clear_best,             // new frame
	input  logic                   done_similarity_metric,
	input  oflow_pkg::metric_vec_t center_dist,
	input  oflow_pkg::metric_vec_t size_diff,
	input  oflow_pkg::set_t        set,
	output oflow_pkg::match_t      best,                   // running best of the frame
	output logic                   done_registration
);

	oflow_pkg::score_t    lane_score [oflow_pkg::PE_NUM];
	logic                 set_found;  // any valid lane in this set
	oflow_pkg::score_t    set_min;
	oflow_pkg::lane_idx_t set_lane;   // lane holding set_min
	logic                 take_set;

	// ----------------------------------------------------------
	// per-lane score and set minimum
	// ----------------------------------------------------------
	always_comb begin
		for (int i = 0; i < oflow_pkg::PE_NUM; i++) begin
			lane_score[i] = oflow_pkg::score_t'(center_dist[i]) +
				oflow_pkg::score_t'(size_diff[i]);
		end
	end

	// strict compare in lane order keeps the lowest lane on a tie
	always_comb begin
		set_found = 1'b0;
		set_min   = '1;
		set_lane  = '0;
		for (int i = 0; i < oflow_pkg::PE_NUM; i++) begin
			if (set.valid[i] && (!set_found || lane_score[i] < set_min)) begin
				set_found = 1'b1;
				set_min   = lane_score[i];
				set_lane  = oflow_pkg::lane_idx_t'(i);
			end
		end
	end

	// earlier sets hold lower indices, so only a strictly better score wins
	assign take_set = set_found && (!best.found || set_min < best.score);

	// ----------------------------------------------------------
	// frame best
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			best              <= '0;
			done_registration <= 1'b0;
		end else begin
			done_registration <= done_similarity_metric;
			if (clear_best) begin
				best.found <= 1'b0;
			end else if (done_similarity_metric && take_set) begin
				best.found <= 1'b1;
				best.idx   <= set.base + oflow_pkg::bbox_idx_t'(set_lane);
				best.score <= set_min;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/oflow_tracker_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module oflow_tracker_top (
	input  logic                 clk,
	input  logic                 reset_N,
	input  logic                 wr_en,                 // memory load port
	input  oflow_pkg::bbox_idx_t wr_addr,
	input  oflow_pkg::bbox_t     wr_bbox,
	input  oflow_pkg::bbox_idx_t num_of_bbox_in_frame,
	input  oflow_pkg::bbox_t     query_bbox,
	input  logic                 start,
	output oflow_pkg::match_t    match,
	output logic                 match_valid
);

	// ----------------------------------------------------------
	// internal nets
	// ----------------------------------------------------------
	oflow_pkg::bbox_idx_t   rd_addr;
	oflow_pkg::bbox_t       rd_data;
	oflow_pkg::set_cnt_t    set_index;
	oflow_pkg::set_t        rd_set;
	oflow_pkg::metric_vec_t center_dist;
	oflow_pkg::metric_vec_t size_diff;
	logic                   start_read;
	logic                   done_read;
	logic                   done_similarity_metric;
	logic                   done_registration;

	oflow_bbox_mem u_mem (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_bbox),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	oflow_core_fsm_read u_fsm (
		.clk                          (clk),
		.reset_N                      (reset_N),
		.num_of_bbox_in_frame         (num_of_bbox_in_frame),
		.start_read_mem_for_first_set (start),
		.done_read                    (done_read),
		.done_registration            (done_registration),
		.start_read                   (start_read),
		.frame_done                   (match_valid), // result ready
		.set_index                    (set_index)
	);

	oflow_buffer_read u_buf (
		.clk                  (clk),
		.reset_N              (reset_N),
		.start_read           (start_read),
		.set_index            (set_index),
		.num_of_bbox_in_frame (num_of_bbox_in_frame),
		.rd_addr              (rd_addr),
		.rd_data              (rd_data),
		.set                  (rd_set),
		.done_read            (done_read)
	);

	// two metric units side by side on the same set
	oflow_center_metric u_center (
		.clk                    (clk),
		.reset_N                (reset_N),
		.done_read              (done_read),
		.set                    (rd_set),
		.query_bbox             (query_bbox),
		.center_dist            (center_dist),
		.done_similarity_metric (done_similarity_metric)
	);

	oflow_size_metric u_size (
		.clk        (clk),
		.reset_N    (reset_N),
		.done_read  (done_read),
		.set        (rd_set),
		.query_bbox (query_bbox),
		.size_diff  (size_diff)
	);

	oflow_registration u_reg (
		.clk                    (clk),
		.reset_N                (reset_N),
		.clear_best             (start),
		.done_similarity_metric (done_similarity_metric),
		.center_dist            (center_dist),
		.size_diff              (size_diff),
		.set                    (rd_set),
		.best                   (match),
		.done_registration      (done_registration)
	);

endmodule

`default_nettype wire

// ==== tests/oflow_tracker_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module oflow_tracker_tb;

	localparam int TIMEOUT_CYC = 400;   // match_valid wait limit
	localparam int SET_CYC     = 28;    // read 25 + metric 1 + registration 1 + restart 1

	logic                 clk;
	logic                 reset_N;
	logic                 wr_en;
	oflow_pkg::bbox_idx_t wr_addr;
	oflow_pkg::bbox_t     wr_bbox;
	oflow_pkg::bbox_idx_t num_of_bbox_in_frame;
	oflow_pkg::bbox_t     query_bbox;
	logic                 start;
	oflow_pkg::match_t    match;
	logic                 match_valid;

	oflow_pkg::bbox_t shadow [oflow_pkg::MEM_DEPTH];  // copy of what the DUT memory holds

	oflow_tracker_top dut (
		.clk                  (clk),
		.reset_N              (reset_N),
		.wr_en                (wr_en),
		.wr_addr              (wr_addr),
		.wr_bbox              (wr_bbox),
		.num_of_bbox_in_frame (num_of_bbox_in_frame),
		.query_bbox           (query_bbox),
		.start                (start),
		.match                (match),
		.match_valid          (match_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	// ----------------------------------------------------------
	// reference model
	// ----------------------------------------------------------
	function automatic int abs_diff(int a, int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// center distance plus size difference, lower is better
	function automatic int box_score(oflow_pkg::bbox_t b, oflow_pkg::bbox_t q);
		return abs_diff(int'(b.x), int'(q.x)) + abs_diff(int'(b.y), int'(q.y)) +
			abs_diff(int'(b.w), int'(q.w)) + abs_diff(int'(b.h), int'(q.h));
	endfunction

	// index order scan, strict compare so the first of equal scores stays
	function automatic oflow_pkg::match_t model_best(int count, oflow_pkg::bbox_t q);
		oflow_pkg::match_t m;
		int                s;
		m = '0;
		for (int i = 0; i < count; i++) begin
			s = box_score(shadow[i], q);
			if (!m.found || s < int'(m.score)) begin
				m.found = 1'b1;
				m.idx   = oflow_pkg::bbox_idx_t'(i);
				m.score = oflow_pkg::score_t'(s);
			end
		end
		return m;
	endfunction

	// ----------------------------------------------------------
	// checks and stimulus helpers
	// ----------------------------------------------------------
	task automatic stop_run(string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eq(string name, int got, int exp);
		assert (got == exp)
		else stop_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_match(oflow_pkg::match_t exp);
		check_eq("match.found", int'(match.found), int'(exp.found));
		if (exp.found) begin                               // idx and score only mean something then
			check_eq("match.idx", int'(match.idx), int'(exp.idx));
			check_eq("match.score", int'(match.score), int'(exp.score));
		end
	endtask

	// every task starts and ends just after a falling edge
	task automatic write_box(int idx, oflow_pkg::bbox_t b);
		wr_en       = 1'b1;
		wr_addr     = oflow_pkg::bbox_idx_t'(idx);
		wr_bbox     = b;
		shadow[idx] = b;
		@(negedge clk);
		wr_en       = 1'b0;
	endtask

	task automatic fill_random(int first, int last);
		for (int i = first; i <= last; i++) begin
			write_box(i, oflow_pkg::bbox_t'($urandom()));
		end
	endtask

	// start pulse, then wait for match_valid with a timeout
	task automatic run_search(int count, oflow_pkg::bbox_t q, output int cycles);
		num_of_bbox_in_frame = oflow_pkg::bbox_idx_t'(count);
		query_bbox           = q;
		start                = 1'b1;
		cycles               = 0;
		do begin
			@(negedge clk);
			start = 1'b0;                                  // one cycle pulse
			cycles++;
		end while (!match_valid && cycles < TIMEOUT_CYC);
		assert (match_valid)
		else stop_run("timeout: match_valid did not arrive within 400 cycles of start");
	endtask

	// latency from the set count, result from the model
	task automatic search_and_check(int count, oflow_pkg::bbox_t q);
		int                cycles;
		int                sets;
		oflow_pkg::match_t exp;
		sets = (count + oflow_pkg::PE_NUM - 1) / oflow_pkg::PE_NUM;
		exp  = model_best(count, q);
		run_search(count, q, cycles);
		check_eq("match_valid latency", cycles, SET_CYC * sets + 1);
		check_match(exp);
	endtask

	// result must hold with no new start
	task automatic hold_check(int n);
		oflow_pkg::match_t snap;
		snap = match;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			check_eq("match_valid", int'(match_valid), 0);
			check_eq("match", int'(match), int'(snap));
		end
	endtask

	// ----------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------
	task automatic test_reset_idle();
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			check_eq("match_valid", int'(match_valid), 0); // nothing started yet
		end
		check_eq("match.found", int'(match.found), 0);
	endtask

	task automatic test_exact_small();
		oflow_pkg::bbox_t q;
		q = oflow_pkg::bbox_t'($urandom());
		fill_random(0, 4);
		write_box(3, q);                                   // exact copy of the query
		search_and_check(5, q);                            // single set, 29 cycles
		check_eq("match.idx", int'(match.idx), 3);
		check_eq("match.score", int'(match.score), 0);
	endtask

	task automatic test_partial_set();
		oflow_pkg::bbox_t q;
		q = oflow_pkg::bbox_t'($urandom());
		fill_random(0, 60);
		for (int i = 61; i <= 71; i++) begin
			write_box(i, q);                               // past the frame end, must be masked
		end
		search_and_check(61, q);                           // 3 sets, last one partial
	endtask

	task automatic test_tie();
		oflow_pkg::bbox_t q;
		q = oflow_pkg::bbox_t'($urandom());
		fill_random(0, 47);
		write_box(7, q);                                   // set 0
		write_box(30, q);                                  // set 1, same score
		search_and_check(48, q);
		check_eq("match.idx", int'(match.idx), 7);
	endtask

	task automatic test_empty();
		search_and_check(0, oflow_pkg::bbox_t'($urandom())); // 1 cycle, found low
	endtask

	task automatic test_back_to_back();
		fill_random(0, 239);                               // 10 full sets
		for (int k = 0; k < 3; k++) begin
			search_and_check(240, oflow_pkg::bbox_t'($urandom()));
			hold_check(8);
		end
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		reset_N              = 1'b0;
		wr_en                = 1'b0;
		wr_addr              = '0;
		wr_bbox              = '0;
		num_of_bbox_in_frame = '0;
		query_bbox           = '0;
		start                = 1'b0;
		void'($urandom(32'hbf54_e637));                    // single seed for the run

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset_N = 1'b1;

		test_reset_idle();
		test_exact_small();
		test_partial_set();
		test_tie();
		test_empty();
		test_back_to_back();

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/oflow_pkg.sv
hdl/oflow_bbox_mem.sv
hdl/oflow_core_fsm_read.sv
hdl/oflow_buffer_read.sv
hdl/oflow_center_metric.sv
hdl/oflow_size_metric.sv
hdl/oflow_registration.sv
hdl/oflow_tracker_top.sv
tests/oflow_tracker_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tracker testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f flist.f --top-module oflow_tracker_tb -o oflow_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/oflow_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

# the log decides
if grep -q "Verification failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation finished clean"
exit 0
